// File: compile.f
+incdir+source
source/mem_pkg.sv
source/mem_client_drv.sv
source/rsp_sorter.sv
source/host_mem_model.sv
source/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: sim/tb_mem_subsys.sv
// Memory subsystem testbench
// Drives client reads and writes, keeps a shadow copy of the host lines
// and checks data, order, write acks and flow control with assertions
`timescale 1ns/10ps

`include "mem_settings.svh"

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int LINES = 1 << `MEM_ADDR_W;
    // The tests need about 600 cycles, so the limit leaves room of about three times
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        resetb;
    mem_addr_t   mem_read_req_addr;
    logic        mem_read_req_enable;
    logic        mem_read_req_rdy;
    mem_data_t   mem_read_rsp_data;
    logic        mem_read_rsp_rdy;
    mem_addr_t   mem_write_addr;
    mem_data_t   mem_write_data;
    logic        mem_write_enable;
    logic        mem_write_rdy;
    wr_ack_cnt_t mem_write_ack;

    // Reference state, updated on every rising edge
    mem_data_t shadow [LINES];
    mem_data_t exp_q [$];
    int        ack_due [$];
    mem_data_t rd_exp_head = '0;
    int        rd_inflight = 0;
    int        rd_pending;
    int        wr_inflight = 0;
    int        exp_ack = 0;
    int        cycle = 0;
    logic      rd_full_seen = 1'b0;
    logic      ack2_seen = 1'b0;
    string     test_name = "reset_state";

    mem_subsys_top u_mem_subsys_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // A response delivered this cycle no longer holds a reorder slot
    assign rd_pending = rd_inflight - int'(mem_read_rsp_rdy);

    // ====================================================================
    // Failure reporting
    // ====================================================================

    task automatic end_in_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic mismatch_found(input string what, input mem_data_t exp, input mem_data_t act);
        $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
        end_in_failure();
    endtask

    task automatic error_found(input string msg);
        $display("Error in %s: %s", test_name, msg);
        end_in_failure();
    endtask

    // ====================================================================
    // Reference model
    // ====================================================================

    always @(posedge clk)
    begin : track
        int n_due;
        if (resetb)
        begin
            if (rd_pending == `MEM_ROB_DEPTH)
                rd_full_seen = 1'b1;
            if (exp_ack == 2)
                ack2_seen = 1'b1;
            // The host samples read data before a same-cycle write lands
            if (mem_read_req_enable && mem_read_req_rdy)
                exp_q.push_back(shadow[mem_read_req_addr]);
            if (mem_read_rsp_rdy && (exp_q.size() > 0))
                void'(exp_q.pop_front());
            if (mem_write_enable && mem_write_rdy)
            begin
                shadow[mem_write_addr] = mem_write_data;
                // Odd lines ack after the odd latency, even lines after the even one
                ack_due.push_back(cycle + (mem_write_addr[0] ? `MEM_WR_LAT_ODD
                                                             : `MEM_WR_LAT_EVEN));
                wr_inflight++;
            end
            wr_inflight = wr_inflight - exp_ack;
            for (int i = ack_due.size() - 1; i >= 0; i--)
            begin
                if (ack_due[i] == cycle)
                    ack_due.delete(i);
            end
            // Acks due in the next cycle
            n_due = 0;
            foreach (ack_due[i])
            begin
                if (ack_due[i] == cycle + 1)
                    n_due++;
            end
            exp_ack = n_due;
            rd_inflight = exp_q.size();
            rd_exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
        end
        cycle++;
        if (cycle >= TIMEOUT_CYCLES)
            error_found($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // ====================================================================
    // Checks
    // ====================================================================

    a_reset_state: assert property (@(posedge clk) $rose(resetb) |->
        ({mem_read_req_rdy, mem_write_rdy, mem_read_rsp_rdy, mem_write_ack} == 5'b11000))
        else mismatch_found("ready, response and ack after reset", 64'h18,
            $sampled({mem_read_req_rdy, mem_write_rdy, mem_read_rsp_rdy, mem_write_ack}));

    a_rsp_expected: assert property (@(posedge clk) disable iff (!resetb)
        mem_read_rsp_rdy |-> (rd_inflight > 0))
        else error_found("read response arrived with no read outstanding");

    a_rsp_data: assert property (@(posedge clk) disable iff (!resetb)
        (mem_read_rsp_rdy && (rd_inflight > 0)) |-> (mem_read_rsp_data == rd_exp_head))
        else mismatch_found("read data", $sampled(rd_exp_head), $sampled(mem_read_rsp_data));

    a_write_ack: assert property (@(posedge clk) disable iff (!resetb)
        mem_write_ack == exp_ack)
        else mismatch_found("write ack count", $sampled(exp_ack), $sampled(mem_write_ack));

    // Read ready drops exactly when every reorder slot holds a read
    a_read_rdy: assert property (@(posedge clk) disable iff (!resetb)
        mem_read_req_rdy == (rd_pending != `MEM_ROB_DEPTH))
        else mismatch_found("read ready", $sampled(rd_pending != `MEM_ROB_DEPTH),
            $sampled(mem_read_req_rdy));

    a_write_rdy: assert property (@(posedge clk) disable iff (!resetb)
        mem_write_rdy == (wr_inflight != `MEM_MAX_WR_OUT))
        else mismatch_found("write ready", $sampled(wr_inflight != `MEM_MAX_WR_OUT),
            $sampled(mem_write_rdy));

    // ====================================================================
    // Stimulus, all driven on the falling edge
    // ====================================================================

    task automatic write_line(input mem_addr_t addr, input mem_data_t data);
        while (!mem_write_rdy)
            @(negedge clk);
        mem_write_addr = addr;
        mem_write_data = data;
        mem_write_enable = 1'b1;
        @(negedge clk);
        mem_write_enable = 1'b0;
    endtask

    task automatic read_line(input mem_addr_t addr);
        while (!mem_read_req_rdy)
            @(negedge clk);
        mem_read_req_addr = addr;
        mem_read_req_enable = 1'b1;
        @(negedge clk);
        mem_read_req_enable = 1'b0;
    endtask

    // Waits for every read response and write ack, the run timeout bounds it
    task automatic wait_idle();
        while ((rd_inflight != 0) || (wr_inflight != 0))
            @(negedge clk);
    endtask

    task automatic read_after_write();
        mem_addr_t written [20];
        test_name = "read_after_write";
        for (int i = 0; i < 20; i++)
        begin
            written[i] = mem_addr_t'($urandom);
            write_line(written[i], {$urandom, $urandom});
        end
        wait_idle();
        for (int i = 0; i < 20; i++)
            read_line(written[i]);
        // Sweep all lines so unwritten ones must come back as zero
        for (int i = 0; i < LINES; i++)
            read_line(mem_addr_t'(i));
        wait_idle();
    endtask

    task automatic in_order_return();
        mem_addr_t addr;
        test_name = "in_order_return";
        // Odd reads return later than the even reads issued after them
        for (int i = 0; i < 12; i++)
        begin
            addr = mem_addr_t'($urandom);
            addr[0] = ~i[0];
            read_line(addr);
        end
        wait_idle();
    endtask

    task automatic write_ack_timing();
        mem_addr_t addr;
        test_name = "write_ack_timing";
        // The even ack and the odd ack fall due in the same cycle
        addr = mem_addr_t'($urandom);
        addr[0] = 1'b0;
        write_line(addr, {$urandom, $urandom});
        addr = mem_addr_t'($urandom);
        addr[0] = 1'b1;
        write_line(addr, {$urandom, $urandom});
        wait_idle();
    endtask

    task automatic read_flow();
        mem_addr_t addr;
        test_name = "read_flow";
        // One odd read held up behind a stream of even returns fills the buffer
        for (int i = 0; i < 48; i++)
        begin
            addr = mem_addr_t'($urandom);
            addr[0] = (i % 24 == 0);
            mem_read_req_addr = addr;
            mem_read_req_enable = mem_read_req_rdy;
            @(negedge clk);
        end
        mem_read_req_enable = 1'b0;
        wait_idle();
    endtask

    task automatic write_flow();
        test_name = "write_flow";
        for (int i = 0; i < 12; i++)
            write_line(mem_addr_t'($urandom), {$urandom, $urandom});
        wait_idle();
    endtask

    initial
    begin
        void'($urandom(70));
        foreach (shadow[i])
            shadow[i] = '0;
        resetb = 1'b0;
        mem_read_req_addr = '0;
        mem_read_req_enable = 1'b0;
        mem_write_addr = '0;
        mem_write_data = '0;
        mem_write_enable = 1'b0;
        repeat (2) @(negedge clk);
        resetb = 1'b1;
        @(negedge clk);
        read_after_write();
        in_order_return();
        write_ack_timing();
        read_flow();
        write_flow();
        if (!rd_full_seen)
            error_found("reorder buffer never held 16 reads");
        else if (!ack2_seen)
            error_found("no cycle had two write acks due");
        else
        begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: source/host_mem_model.sv
// Host memory model
// Line storage that stands in for the platform, with read returns and
// write acks delayed by address-dependent latencies
`timescale 1ns/10ps

`include "mem_settings.svh"

module host_mem_model
(
    input  logic               clk,
    input  logic               resetb,

    // Channel 0 reads and their returns
    input  logic               c0_tx_valid,
    input  mem_pkg::mem_addr_t c0_tx_addr,
    input  mem_pkg::mem_tag_t  c0_tx_tag,
    output logic               c0_rx_rd_valid,
    output mem_pkg::mem_tag_t  c0_rx_tag,
    output mem_pkg::mem_data_t c0_rx_data,

    // Channel 1 writes and acks on both channels
    input  logic               c1_tx_valid,
    input  mem_pkg::mem_addr_t c1_tx_addr,
    input  mem_pkg::mem_data_t c1_tx_data,
    output logic               c0_rx_wr_valid,
    output logic               c1_rx_wr_valid
);

    import mem_pkg::*;

    localparam int LINES = 1 << `MEM_ADDR_W;
    localparam int RE = `MEM_RD_LAT_EVEN;
    localparam int RO = `MEM_RD_LAT_ODD;

    mem_data_t lines [LINES];

    // Read return pipelines, one stage per cycle of latency
    logic [RE-1:0] rd_even_vld;
    mem_tag_t      rd_even_tag [RE];
    mem_data_t     rd_even_data [RE];
    logic [RO-1:0] rd_odd_vld;
    mem_tag_t      rd_odd_tag [RO];
    mem_data_t     rd_odd_data [RO];

    // Write ack pipelines, even lines ack on channel 1 and odd on channel 0
    logic [`MEM_WR_LAT_EVEN-1:0] wr_even_sr;
    logic [`MEM_WR_LAT_ODD-1:0]  wr_odd_sr;

    // Odd returns that lost the return port to an even one
    mem_tag_t            hold_tag [`MEM_ROB_DEPTH];
    mem_data_t           hold_data [`MEM_ROB_DEPTH];
    mem_tag_t            hold_wr_ptr;
    mem_tag_t            hold_rd_ptr;
    logic [`MEM_TAG_W:0] hold_cnt;

    logic even_done;
    logic odd_done;
    logic hold_empty;
    logic hold_push;
    logic hold_pop;
    logic odd_direct;

    // ====================================================================
    // Return port arbitration
    // ====================================================================

    assign even_done = rd_even_vld[RE-1];
    assign odd_done = rd_odd_vld[RO-1];
    assign hold_empty = (hold_cnt == '0);

    // Even returns always win, and held odd returns go before fresh ones
    assign hold_pop = !even_done && !hold_empty;
    assign odd_direct = !even_done && hold_empty && odd_done;
    assign hold_push = odd_done && !odd_direct;

    assign c0_rx_rd_valid = even_done || hold_pop || odd_direct;

    always_comb
    begin
        if (even_done)
        begin
            c0_rx_tag = rd_even_tag[RE-1];
            c0_rx_data = rd_even_data[RE-1];
        end
        else if (!hold_empty)
        begin
            c0_rx_tag = hold_tag[hold_rd_ptr];
            c0_rx_data = hold_data[hold_rd_ptr];
        end
        else
        begin
            c0_rx_tag = rd_odd_tag[RO-1];
            c0_rx_data = rd_odd_data[RO-1];
        end
    end

    assign c1_rx_wr_valid = wr_even_sr[`MEM_WR_LAT_EVEN-1];
    assign c0_rx_wr_valid = wr_odd_sr[`MEM_WR_LAT_ODD-1];

    // ====================================================================
    // Control state
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rd_even_vld <= '0;
            rd_odd_vld <= '0;
            wr_even_sr <= '0;
            wr_odd_sr <= '0;
            hold_wr_ptr <= '0;
            hold_rd_ptr <= '0;
            hold_cnt <= '0;
        end
        else
        begin
            rd_even_vld <= {rd_even_vld[RE-2:0], c0_tx_valid && !c0_tx_addr[0]};
            rd_odd_vld <= {rd_odd_vld[RO-2:0], c0_tx_valid && c0_tx_addr[0]};
            wr_even_sr <= {wr_even_sr[`MEM_WR_LAT_EVEN-2:0], c1_tx_valid && !c1_tx_addr[0]};
            wr_odd_sr <= {wr_odd_sr[`MEM_WR_LAT_ODD-2:0], c1_tx_valid && c1_tx_addr[0]};
            if (hold_push)
                hold_wr_ptr <= hold_wr_ptr + 1'b1;
            if (hold_pop)
                hold_rd_ptr <= hold_rd_ptr + 1'b1;
            hold_cnt <= hold_cnt + hold_push - hold_pop;
        end
    end

    // Payload stages; data is sampled from storage in the request cycle
    always_ff @(posedge clk)
    begin
        rd_even_tag[0] <= c0_tx_tag;
        rd_even_data[0] <= lines[c0_tx_addr];
        for (int i = 1; i < RE; i++)
        begin
            rd_even_tag[i] <= rd_even_tag[i-1];
            rd_even_data[i] <= rd_even_data[i-1];
        end
        rd_odd_tag[0] <= c0_tx_tag;
        rd_odd_data[0] <= lines[c0_tx_addr];
        for (int i = 1; i < RO; i++)
        begin
            rd_odd_tag[i] <= rd_odd_tag[i-1];
            rd_odd_data[i] <= rd_odd_data[i-1];
        end
        if (hold_push)
        begin
            hold_tag[hold_wr_ptr] <= rd_odd_tag[RO-1];
            hold_data[hold_wr_ptr] <= rd_odd_data[RO-1];
        end
    end

    // Line storage, cleared by reset and written in the request cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            for (int i = 0; i < LINES; i++)
                lines[i] <= '0;
        end
        else if (c1_tx_valid)
            lines[c1_tx_addr] <= c1_tx_data;
    end

    // The reorder buffer limits reads in flight, so the hold queue never fills
    a_hold_no_overflow: assert property (@(posedge clk) disable iff (!resetb)
        hold_push |-> (hold_cnt < `MEM_ROB_DEPTH) || hold_pop)
        else $error("host_mem_model: odd return hold queue overflow");

endmodule

// File: source/mem_client_drv.sv
// Client memory driver
// Forwards client line reads to the reorder buffer and line writes to
// host channel 1, limits writes in flight and sums the host write acks
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_client_drv
(
    input  logic                clk,
    input  logic                resetb,

    // Client read request and in-order response
    input  mem_pkg::mem_addr_t  mem_read_req_addr,
    input  logic                mem_read_req_enable,
    output logic                mem_read_req_rdy,
    output logic                mem_read_rsp_rdy,
    output mem_pkg::mem_data_t  mem_read_rsp_data,

    // Client write request and ack count
    input  mem_pkg::mem_addr_t  mem_write_addr,
    input  mem_pkg::mem_data_t  mem_write_data,
    input  logic                mem_write_enable,
    output logic                mem_write_rdy,
    output mem_pkg::wr_ack_cnt_t mem_write_ack,

    // Reorder buffer side
    output logic                rd_req_valid,
    output mem_pkg::mem_addr_t  rd_req_addr,
    input  logic                rd_alm_full,
    input  logic                rsp_valid,
    input  mem_pkg::mem_data_t  rsp_data,

    // Host channel 1 write requests and acks from both channels
    output logic                c1_tx_valid,
    output mem_pkg::mem_addr_t  c1_tx_addr,
    output mem_pkg::mem_data_t  c1_tx_data,
    input  logic                c0_rx_wr_valid,
    input  logic                c1_rx_wr_valid
);

    import mem_pkg::*;

    // Wide enough to hold 0 to MEM_MAX_WR_OUT
    localparam int WR_CNT_W = $clog2(`MEM_MAX_WR_OUT + 1);

    logic [WR_CNT_W-1:0] wr_out;
    logic                wr_accept;

    // ====================================================================
    // Read path
    // ====================================================================

    // Reads go straight to the reorder buffer, which tags them
    assign rd_req_valid = mem_read_req_enable;
    assign rd_req_addr = mem_read_req_addr;
    assign mem_read_req_rdy = !rd_alm_full;

    // Responses are already in request order here
    assign mem_read_rsp_rdy = rsp_valid;
    assign mem_read_rsp_data = rsp_data;

    // ====================================================================
    // Write path
    // ====================================================================

    assign c1_tx_valid = mem_write_enable;
    assign c1_tx_addr = mem_write_addr;
    assign c1_tx_data = mem_write_data;

    // Odd lines ack on channel 0 and even lines on channel 1
    assign mem_write_ack = wr_ack_cnt_t'(c0_rx_wr_valid) + wr_ack_cnt_t'(c1_rx_wr_valid);

    assign wr_accept = mem_write_enable && mem_write_rdy;
    assign mem_write_rdy = (wr_out < WR_CNT_W'(`MEM_MAX_WR_OUT));

    // Writes in flight, up on each accepted write and down by the ack count
    always_ff @(posedge clk)
    begin
        if (!resetb)
            wr_out <= '0;
        else
            wr_out <= wr_out + WR_CNT_W'(wr_accept) - WR_CNT_W'(mem_write_ack);
    end

    // The client must hold enable low whenever the matching ready is low
    a_rd_enable_rdy: assert property (@(posedge clk) disable iff (!resetb)
        mem_read_req_enable |-> mem_read_req_rdy)
        else $error("mem_client_drv: read enable while not ready");

    a_wr_enable_rdy: assert property (@(posedge clk) disable iff (!resetb)
        mem_write_enable |-> mem_write_rdy)
        else $error("mem_client_drv: write enable while not ready");

    // The host may only ack writes that were sent in an earlier cycle
    a_wr_no_underflow: assert property (@(posedge clk) disable iff (!resetb)
        WR_CNT_W'(mem_write_ack) <= wr_out)
        else $error("mem_client_drv: more write acks than writes in flight");

endmodule

// File: source/mem_pkg.sv
// Memory subsystem types
// Line address, line data and tag vectors, the write ack count and the
// state of one reorder buffer slot

`include "mem_settings.svh"

package mem_pkg;

    // ====================================================================
    // Vector types
    // ====================================================================

    // One cache line address, in units of whole lines
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // One full line of data
    typedef logic [`MEM_DATA_W-1:0] mem_data_t;

    // Read tag, which is also the reorder buffer slot index
    typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

    // Write acks per cycle
    // Both host channels may ack in the same cycle, so the count reaches 2
    typedef logic [1:0] wr_ack_cnt_t;

    // ====================================================================
    // Reorder buffer slot state
    // ====================================================================

    // A slot is free, waits for its host completion, or holds data that
    // has not yet been released in request order
    typedef enum logic [1:0]
    {
        SLOT_FREE = 2'd0,
        SLOT_WAIT = 2'd1,
        SLOT_FULL = 2'd2
    } slot_state_e;

endpackage

// File: source/mem_settings.svh
// Memory subsystem settings
// Widths, buffer depths and host latencies shared by the driver, the
// read reorder buffer and the host memory model
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Line address and line data widths
// The host model holds 2**MEM_ADDR_W lines
`define MEM_ADDR_W 6
`define MEM_DATA_W 64

// Read tags index the reorder buffer, so the depth is 2**MEM_TAG_W
`define MEM_TAG_W 4
`define MEM_ROB_DEPTH 16

// Host read return latency in cycles, chosen by line address bit 0
`define MEM_RD_LAT_EVEN 2
`define MEM_RD_LAT_ODD 6

// Host write ack latency in cycles, chosen by line address bit 0
`define MEM_WR_LAT_EVEN 3
`define MEM_WR_LAT_ODD 2

// Writes allowed in flight before the client sees write ready drop
`define MEM_MAX_WR_OUT 4

`endif

// File: source/mem_subsys_top.sv
// Memory subsystem top level
// Connects the client driver, the read reorder buffer and the host
// memory model into one block with the client ports outside
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_subsys_top
(
    input  logic                 clk,
    input  logic                 resetb,

    // Client reads
    input  mem_pkg::mem_addr_t   mem_read_req_addr,
    input  logic                 mem_read_req_enable,
    output logic                 mem_read_req_rdy,
    output mem_pkg::mem_data_t   mem_read_rsp_data,
    output logic                 mem_read_rsp_rdy,

    // Client writes
    input  mem_pkg::mem_addr_t   mem_write_addr,
    input  mem_pkg::mem_data_t   mem_write_data,
    input  logic                 mem_write_enable,
    output logic                 mem_write_rdy,
    output mem_pkg::wr_ack_cnt_t mem_write_ack
);

    import mem_pkg::*;

    // Driver to reorder buffer
    logic      rd_req_valid;
    mem_addr_t rd_req_addr;
    logic      rd_alm_full;
    logic      rsp_valid;
    mem_data_t rsp_data;

    // Host channel 0
    logic      c0_tx_valid;
    mem_addr_t c0_tx_addr;
    mem_tag_t  c0_tx_tag;
    logic      c0_rx_rd_valid;
    mem_tag_t  c0_rx_tag;
    mem_data_t c0_rx_data;
    logic      c0_rx_wr_valid;

    // Host channel 1
    logic      c1_tx_valid;
    mem_addr_t c1_tx_addr;
    mem_data_t c1_tx_data;
    logic      c1_rx_wr_valid;

    // All port names match the nets above, so the blocks connect by name
    mem_client_drv u_drv (.*);

    rsp_sorter u_sorter (.*);

    host_mem_model u_host (.*);

endmodule

// File: source/rsp_sorter.sv
// Read response sorter
// Tags each read with a reorder buffer slot, stores out-of-order host
// completions by tag and releases them to the driver in request order
`timescale 1ns/10ps

`include "mem_settings.svh"

module rsp_sorter
(
    input  logic               clk,
    input  logic               resetb,

    // Read requests from the driver
    input  logic               rd_req_valid,
    input  mem_pkg::mem_addr_t rd_req_addr,
    output logic               rd_alm_full,

    // Tagged requests to host channel 0
    output logic               c0_tx_valid,
    output mem_pkg::mem_addr_t c0_tx_addr,
    output mem_pkg::mem_tag_t  c0_tx_tag,

    // Host completions, in any order
    input  logic               c0_rx_rd_valid,
    input  mem_pkg::mem_tag_t  c0_rx_tag,
    input  mem_pkg::mem_data_t c0_rx_data,

    // In-order responses to the driver
    output logic               rsp_valid,
    output mem_pkg::mem_data_t rsp_data
);

    import mem_pkg::*;

    slot_state_e slot_state [`MEM_ROB_DEPTH];
    mem_data_t   slot_data [`MEM_ROB_DEPTH];

    // Allocate pointer hands out tags, release pointer marks the oldest read
    mem_tag_t  alloc_ptr;
    mem_tag_t  rel_ptr;

    logic      head_hit;
    logic      head_full;
    logic      release_head;
    logic      rx_store;
    mem_data_t release_data;

    // ====================================================================
    // Allocation
    // ====================================================================

    // Slots are taken and freed in ring order, so a busy slot under the
    // allocate pointer means every slot is in use
    assign rd_alm_full = (slot_state[alloc_ptr] != SLOT_FREE);

    // The request goes to the host in the cycle it is accepted
    assign c0_tx_valid = rd_req_valid;
    assign c0_tx_addr = rd_req_addr;
    assign c0_tx_tag = alloc_ptr;

    // ====================================================================
    // Completion and release
    // ====================================================================

    // A completion for the head slot bypasses storage and goes out on the
    // next cycle
    assign head_hit = c0_rx_rd_valid && (c0_rx_tag == rel_ptr);
    assign head_full = (slot_state[rel_ptr] == SLOT_FULL);
    assign release_head = head_full || head_hit;
    assign release_data = head_hit ? c0_rx_data : slot_data[rel_ptr];

    // Completions behind the head wait in their slot
    assign rx_store = c0_rx_rd_valid && !head_hit;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            for (int i = 0; i < `MEM_ROB_DEPTH; i++)
                slot_state[i] <= SLOT_FREE;
            alloc_ptr <= '0;
            rel_ptr <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (rd_req_valid)
            begin
                slot_state[alloc_ptr] <= SLOT_WAIT;
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (rx_store)
                slot_state[c0_rx_tag] <= SLOT_FULL;

            // At most one slot leaves per cycle, always the oldest one
            if (release_head)
            begin
                slot_state[rel_ptr] <= SLOT_FREE;
                rel_ptr <= rel_ptr + 1'b1;
            end

            rsp_valid <= release_head;
        end
    end

    // Line storage and the registered response data
    always_ff @(posedge clk)
    begin
        if (rx_store)
            slot_data[c0_rx_tag] <= c0_rx_data;
        rsp_data <= release_data;
    end

    // The host must only complete reads that are still outstanding
    a_rx_tag_waiting: assert property (@(posedge clk) disable iff (!resetb)
        c0_rx_rd_valid |-> (slot_state[c0_rx_tag] == SLOT_WAIT))
        else $error("rsp_sorter: completion for tag %0d not in flight", c0_rx_tag);

    // The driver must stall reads while the buffer is full
    a_no_req_when_full: assert property (@(posedge clk) disable iff (!resetb)
        rd_req_valid |-> !rd_alm_full)
        else $error("rsp_sorter: read request while reorder buffer full");

endmodule
